// ==== cpu_consts.svh ====
`ifndef CPU_CONSTS_SVH
`define CPU_CONSTS_SVH

// datapath word width
`define WORD_W 32

// first fetch address after reset
`define RESET_PC 32'h1c00_0000

// common entry for adef and syscall
`define EXCP_ENTRY 32'h1c00_8000

// major opcode field inst[31:26]
`define OP_B 6'b010100
`define OP_BL 6'b010101

// syscall matches on inst[31:15] and leaves the code field below free
`define INST_SYSCALL_HI 17'h00056

// ertn has one fixed encoding
`define INST_ERTN 32'h0648_3800

`endif

// ==== ctrl_pkg.sv ====
`default_nettype none

package ctrl_pkg;

    `include "cpu_consts.svh"

    // per-stage hold strobes
    typedef struct packed {
        logic if_hold;
        logic id_hold;
    } hold_t;

    typedef enum logic [1:0] {
        EXCP_NONE,
        EXCP_ADEF,
        EXCP_SYS
    } excp_code_e;

    // pc override towards fetch
    typedef struct packed {
        logic               flush;
        logic [`WORD_W-1:0] new_pc;
    } redirect_t;

    // what decode tells control about the instruction leaving it
    typedef struct packed {
        logic               fire;
        logic [`WORD_W-1:0] pc;
        excp_code_e         excp;
        logic               is_ertn;
    } ds_event_t;

endpackage

`default_nettype wire

// ==== pipe_pkg.sv ====
`default_nettype none

package pipe_pkg;

    import ctrl_pkg::*;

    `include "cpu_consts.svh"

    // valid on the fetch bus means the sram request went out
    typedef struct packed {
        logic [`WORD_W-1:0] pc;
        logic               adef;
        logic               valid;
    } fs_to_ds_t;

    // direct jump resolved in decode
    typedef struct packed {
        logic               taken;
        logic [`WORD_W-1:0] target;
    } br_bus_t;

    typedef enum logic [2:0] {
        CLS_SEQ,
        CLS_B,
        CLS_BL,
        CLS_SYSCALL,
        CLS_ERTN
    } inst_class_e;

    // decode output towards execute
    typedef struct packed {
        logic               valid;
        logic [`WORD_W-1:0] pc;
        logic [`WORD_W-1:0] inst;
        inst_class_e        cls;
        excp_code_e         excp;
    } ds_to_es_t;

endpackage

`default_nettype wire

// ==== if_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "cpu_consts.svh"

module if_stage
    import ctrl_pkg::*;
    import pipe_pkg::*;
(
    input  wire logic               clk,
    input  wire logic               reset,
    input  wire hold_t              hold,
    input  wire redirect_t          redirect,
    input  wire br_bus_t            br_bus,
    output logic                    inst_sram_en,
    output logic [`WORD_W-1:0]      inst_sram_addr,
    output fs_to_ds_t               fs_to_ds
);

    logic               pc_valid;
    logic [`WORD_W-1:0] fs_pc;
    logic [`WORD_W-1:0] seq_pc;
    logic [`WORD_W-1:0] next_pc;
    logic               fetch;

    assign seq_pc = fs_pc + `WORD_W'd4;

    // flush beats a jump, a jump beats the sequential pc
    always_comb begin
        if (redirect.flush) begin
            next_pc = redirect.new_pc;
        end else if (br_bus.taken) begin
            next_pc = br_bus.target;
        end else begin
            next_pc = seq_pc;
        end
    end

    // starts one word below the reset pc so the first step lands on it
    always_ff @(posedge clk) begin
        if (reset) begin
            pc_valid <= 1'b0;
            fs_pc    <= `RESET_PC - `WORD_W'd4;
        end else if (redirect.flush || !hold.if_hold) begin
            pc_valid <= 1'b1;
            fs_pc    <= next_pc;
        end
    end

    // no request when held, or when this pc is about to be thrown away
    assign fetch = pc_valid && !hold.if_hold && !br_bus.taken && !redirect.flush;

    assign inst_sram_en   = fetch;
    assign inst_sram_addr = fs_pc;

    assign fs_to_ds.pc    = fs_pc;
    assign fs_to_ds.adef  = |fs_pc[1:0];
    assign fs_to_ds.valid = fetch;

    // a held cycle issues nothing and the pc does not move under it
    a_no_fetch_in_hold: assert property (
        @(posedge clk) disable iff (reset)
        hold.if_hold |-> !inst_sram_en ##1 $stable(fs_pc)
    ) else $error("fetch issued or pc moved while fetch was held");

endmodule

`default_nettype wire

// ==== id_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "cpu_consts.svh"

module id_stage
    import ctrl_pkg::*;
    import pipe_pkg::*;
(
    input  wire logic               clk,
    input  wire logic               reset,
    input  wire hold_t              hold,
    input  wire redirect_t          redirect,
    input  wire fs_to_ds_t          fs_to_ds,
    input  wire logic [`WORD_W-1:0] inst_sram_rdata,
    output br_bus_t                 br_bus,
    output ds_event_t               ds_event,
    output ds_to_es_t               ds_to_es,
    input  wire logic               es_stall
);

    logic               ds_valid;
    logic [`WORD_W-1:0] ds_pc;
    logic               ds_adef;

    logic               inst_buf_valid;
    logic [`WORD_W-1:0] inst_buf;
    logic [`WORD_W-1:0] inst;

    logic [5:0]         opcode;
    logic [25:0]        offs26;
    logic [`WORD_W-1:0] jump_target;
    inst_class_e        cls;
    excp_code_e         excp;
    logic               fire;

    always_ff @(posedge clk) begin
        if (reset) begin
            ds_valid <= 1'b0;
        end else if (redirect.flush) begin
            ds_valid <= 1'b0;
        end else if (!hold.id_hold) begin
            ds_valid <= fs_to_ds.valid;
        end
    end

    always_ff @(posedge clk) begin
        if (!hold.id_hold && fs_to_ds.valid) begin
            ds_pc   <= fs_to_ds.pc;
            ds_adef <= fs_to_ds.adef;
        end
    end

    // copy of the sram word, which is only good on the first held cycle
    always_ff @(posedge clk) begin
        if (reset) begin
            inst_buf_valid <= 1'b0;
        end else if (redirect.flush || !hold.id_hold) begin
            inst_buf_valid <= 1'b0;
        end else if (!inst_buf_valid) begin
            inst_buf_valid <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (hold.id_hold && !inst_buf_valid) begin
            inst_buf <= inst_sram_rdata;
        end
    end

    assign inst = inst_buf_valid ? inst_buf : inst_sram_rdata;

    assign opcode = inst[31:26];
    // offs26 is stored split with its low half in bits 25:10
    assign offs26 = {inst[9:0], inst[25:10]};
    assign jump_target = ds_pc + {{4{offs26[25]}}, offs26, 2'b00};

    always_comb begin
        cls = CLS_SEQ;
        if (opcode == `OP_B) begin
            cls = CLS_B;
        end else if (opcode == `OP_BL) begin
            cls = CLS_BL;
        end else if (inst[31:15] == `INST_SYSCALL_HI) begin
            cls = CLS_SYSCALL;
        end else if (inst == `INST_ERTN) begin
            cls = CLS_ERTN;
        end
    end

    // fetch fault wins over syscall
    always_comb begin
        if (ds_adef) begin
            excp = EXCP_ADEF;
        end else if (cls == CLS_SYSCALL) begin
            excp = EXCP_SYS;
        end else begin
            excp = EXCP_NONE;
        end
    end

    assign fire = ds_valid && !es_stall;

    assign br_bus.taken  = fire && (cls == CLS_B || cls == CLS_BL) && excp == EXCP_NONE;
    assign br_bus.target = jump_target;

    assign ds_event.fire    = fire;
    assign ds_event.pc      = ds_pc;
    assign ds_event.excp    = excp;
    assign ds_event.is_ertn = (cls == CLS_ERTN) && excp == EXCP_NONE;

    assign ds_to_es.valid = ds_valid;
    assign ds_to_es.pc    = ds_pc;
    assign ds_to_es.inst  = inst;
    assign ds_to_es.cls   = cls;
    assign ds_to_es.excp  = excp;

    // fetch drops the delay-slot request, so a bubble follows every jump
    a_jump_clean: assert property (
        @(posedge clk) disable iff (reset)
        br_bus.taken |-> excp == EXCP_NONE ##1 !ds_to_es.valid
    ) else $error("jump taken with an exception or followed by a live slot");

endmodule

`default_nettype wire

// ==== ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "cpu_consts.svh"

module ctrl
    import ctrl_pkg::*;
(
    input  wire logic      clk,
    input  wire logic      reset,
    input  wire logic      es_stall,
    input  wire ds_event_t ds_event,
    output hold_t          hold,
    output redirect_t      redirect
);

    logic [`WORD_W-1:0] era;
    logic               take_excp;
    logic               take_ertn;
    logic               flush;

    // execute back-pressure freezes both stages together
    assign hold.if_hold = es_stall;
    assign hold.id_hold = es_stall;

    // only an accepted instruction may redirect
    assign take_excp = ds_event.fire && ds_event.excp != EXCP_NONE;
    assign take_ertn = ds_event.fire && ds_event.is_ertn;

    assign flush = take_excp || take_ertn;

    assign redirect.flush = flush;

    always_comb begin
        if (take_excp) begin
            redirect.new_pc = `EXCP_ENTRY;
        end else begin
            // ertn returns to the faulting or trapping pc
            redirect.new_pc = era;
        end
    end

    // era holds the pc of the instruction that raised the exception
    always_ff @(posedge clk) begin
        if (reset) begin
            era <= '0;
        end else if (take_excp) begin
            era <= ds_event.pc;
        end
    end

    // decode is emptied by a flush, so the next cycle cannot fire again
    a_single_flush: assert property (
        @(posedge clk) disable iff (reset)
        redirect.flush |=> !redirect.flush
    ) else $error("flush held for two cycles in a row");

endmodule

`default_nettype wire

// ==== frontend_top.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "cpu_consts.svh"

module frontend_top
    import ctrl_pkg::*;
    import pipe_pkg::*;
(
    input  wire logic               clk,
    input  wire logic               reset,
    input  wire logic               es_stall,
    output logic                    inst_sram_en,
    output logic [`WORD_W-1:0]      inst_sram_addr,
    input  wire logic [`WORD_W-1:0] inst_sram_rdata,
    output ds_to_es_t               ds_to_es
);

    // read-only instruction port with the write side tied off at the sram

    hold_t     hold;
    redirect_t redirect;
    br_bus_t   br_bus;
    fs_to_ds_t fs_to_ds;
    ds_event_t ds_event;

    if_stage u_if_stage (
        .clk            (clk),
        .reset          (reset),
        .hold           (hold),
        .redirect       (redirect),
        .br_bus         (br_bus),
        .inst_sram_en   (inst_sram_en),
        .inst_sram_addr (inst_sram_addr),
        .fs_to_ds       (fs_to_ds)
    );

    id_stage u_id_stage (
        .clk             (clk),
        .reset           (reset),
        .hold            (hold),
        .redirect        (redirect),
        .fs_to_ds        (fs_to_ds),
        .inst_sram_rdata (inst_sram_rdata),
        .br_bus          (br_bus),
        .ds_event        (ds_event),
        .ds_to_es        (ds_to_es),
        .es_stall        (es_stall)
    );

    ctrl u_ctrl (
        .clk      (clk),
        .reset    (reset),
        .es_stall (es_stall),
        .ds_event (ds_event),
        .hold     (hold),
        .redirect (redirect)
    );

endmodule

`default_nettype wire

// ==== tb_frontend.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "cpu_consts.svh"

module tb_frontend
    import ctrl_pkg::*;
    import pipe_pkg::*;
();

    // layout of input_mem, matching the @ markers in the input file
    localparam int IMAGE_WORDS = 64;
    localparam int MAIN_BASE   = 0;
    localparam int EXCP_BASE   = 64;
    localparam int TRACE_COUNT = 128;
    localparam int TRACE_BASE  = 129;
    localparam int MEM_WORDS   = 256;
    localparam int WAIT_LIMIT  = 64;

    logic               clk;
    logic               reset;
    logic               es_stall;
    logic               inst_sram_en;
    logic [`WORD_W-1:0] inst_sram_addr;
    logic [`WORD_W-1:0] inst_sram_rdata = '0;
    ds_to_es_t          ds_to_es;

    logic [`WORD_W-1:0] input_mem [0:MEM_WORDS-1];

    int     trace_len;
    int     error_count;
    int     check_count;
    int     test_count;
    integer seed;

    frontend_top u_dut (
        .clk             (clk),
        .reset           (reset),
        .es_stall        (es_stall),
        .inst_sram_en    (inst_sram_en),
        .inst_sram_addr  (inst_sram_addr),
        .inst_sram_rdata (inst_sram_rdata),
        .ds_to_es        (ds_to_es)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // filler for unmapped words is unique to each address
    function automatic logic [`WORD_W-1:0] fill_word(input logic [`WORD_W-1:0] addr);
        return {addr[15:0], addr[31:16]} ^ 32'h3c3c_c3c3;
    endfunction

    function automatic logic [`WORD_W-1:0] sram_read(input logic [`WORD_W-1:0] addr);
        logic [`WORD_W-1:0] main_off;
        logic [`WORD_W-1:0] excp_off;
        main_off = addr - `RESET_PC;
        excp_off = addr - `EXCP_ENTRY;
        if (main_off < 4 * IMAGE_WORDS) begin
            return input_mem[MAIN_BASE + main_off[31:2]];
        end else if (excp_off < 4 * IMAGE_WORDS) begin
            return input_mem[EXCP_BASE + excp_off[31:2]];
        end
        return fill_word(addr);
    endfunction

    // synchronous read port keeps its word until the next request
    always @(posedge clk) begin
        if (inst_sram_en) begin
            inst_sram_rdata <= sram_read(inst_sram_addr);
        end
    end

    function automatic ds_to_es_t trace_entry(input int n);
        ds_to_es_t e;
        int        base;
        base   = TRACE_BASE + 4 * n;
        e.valid = 1'b1;
        e.pc    = input_mem[base];
        e.inst  = input_mem[base + 1];
        e.cls   = inst_class_e'(input_mem[base + 2][2:0]);
        e.excp  = excp_code_e'(input_mem[base + 3][1:0]);
        return e;
    endfunction

    function automatic logic stall_for(input int mode, input int cyc);
        logic stall;
        stall = 1'b0;
        if (mode == 1) begin
            // about three cycles in ten
            stall = ($unsigned($random(seed)) % 100) < 30;
        end else if (mode == 2) begin
            // one long burst, then short ones that drift across the jumps
            stall = (cyc >= 6 && cyc < 18) || (cyc >= 18 && cyc % 7 < 3);
        end
        return stall;
    endfunction

    task automatic check_ds(input string what, input ds_to_es_t got, input ds_to_es_t exp);
        check_count++;
        if (got !== exp) begin
            error_count++;
            $display("mismatch at time %0t: %s got valid %b pc %h inst %h %s %s",
                     $time, what, got.valid, got.pc, got.inst,
                     got.cls.name(), got.excp.name());
            $display("    expected pc %h inst %h %s %s",
                     exp.pc, exp.inst, exp.cls.name(), exp.excp.name());
        end
    endtask

    task automatic check_addr(input string what, input logic [`WORD_W-1:0] got,
                              input logic [`WORD_W-1:0] exp);
        check_count++;
        if (got !== exp) begin
            error_count++;
            $display("mismatch at time %0t: %s got %h expected %h", $time, what, got, exp);
        end
    endtask

    task automatic apply_reset();
        @(posedge clk);
        reset    <= 1'b1;
        es_stall <= 1'b0;
        repeat (2) @(posedge clk);
        reset <= 1'b0;
    endtask

    task automatic load_input();
        int i;
        for (i = 0; i < IMAGE_WORDS; i++) begin
            input_mem[MAIN_BASE + i] = fill_word(`RESET_PC + 4 * i);
            input_mem[EXCP_BASE + i] = fill_word(`EXCP_ENTRY + 4 * i);
        end
        $readmemh("frontend_input.txt", input_mem);
        trace_len = input_mem[TRACE_COUNT];
        if (trace_len <= 0 || TRACE_BASE + 4 * trace_len > MEM_WORDS) begin
            error_count++;
            $display("input file has no usable trace section");
            trace_len = 0;
        end
    endtask

    // run the whole trace once, sampling at the falling edge
    task automatic run_test(input string name, input int mode);
        int                 idx;
        int                 idle;
        int                 cyc;
        int                 errors_at_start;
        logic [`WORD_W-1:0] fetch_addr;
        ds_to_es_t          expected;
        errors_at_start = error_count;
        idx             = 0;
        idle            = 0;
        cyc             = 0;
        fetch_addr      = '0;
        test_count++;
        apply_reset();
        while (idx < trace_len && idle < WAIT_LIMIT) begin
            @(posedge clk);
            es_stall <= stall_for(mode, cyc);
            @(negedge clk);
            if (es_stall) begin
                check_addr("sram enable under es_stall",
                           {{(`WORD_W-1){1'b0}}, inst_sram_en}, '0);
            end
            if (ds_to_es.valid && !es_stall) begin
                expected = trace_entry(idx);
                check_ds($sformatf("trace entry %0d", idx), ds_to_es, expected);
                // the word in decode came from the last request before this cycle
                check_addr($sformatf("sram address of trace entry %0d", idx),
                           fetch_addr, expected.pc);
                idx++;
                idle = 0;
            end else begin
                idle++;
            end
            if (inst_sram_en) begin
                fetch_addr = inst_sram_addr;
            end
            cyc++;
        end
        if (idx < trace_len) begin
            error_count++;
            $display("test %s: trace entry %0d at pc %h never arrived within %0d cycles",
                     name, idx, input_mem[TRACE_BASE + 4 * idx], WAIT_LIMIT);
        end
        $display("test %s: %0d of %0d trace entries accepted, %0d errors",
                 name, idx, trace_len, error_count - errors_at_start);
    endtask

    initial begin
        reset       = 1'b1;
        es_stall    = 1'b0;
        seed        = 32'h3092;
        error_count = 0;
        check_count = 0;
        test_count  = 0;
        load_input();
        run_test("no_stall", 0);
        run_test("random_stall", 1);
        run_test("burst_stall", 2);
        $display("%0d tests, %0d checks, %0d errors", test_count, check_count, error_count);
        if (error_count == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== frontend_input.txt ====
// @00 program at RESET_PC and @40 program at EXCP_ENTRY, one word per line
// @80 trace entry count, then one entry per line: pc inst cls excp
// cls 0 seq 1 b 2 bl 3 syscall 4 ertn, excp 0 none 1 adef 2 sys
@00
02800421
02800842
00100c61
50000c00 // b +3
0280fc63
02801084
54001000 // bl +4
028014a5
028018c6
50000c00 // b +3
02801ce7
53fff7ff // b -3
00101508
002b0011 // syscall
02802129
@40
0280252a
06483800 // ertn
0280294a
@80
00000010
1c000000 02800421 0 0
1c000004 02800842 0 0
1c000008 00100c61 0 0
1c00000c 50000c00 1 0
1c000018 54001000 2 0
1c000028 02801ce7 0 0
1c00002c 53fff7ff 1 0
1c000020 028018c6 0 0
1c000024 50000c00 1 0
1c000030 00101508 0 0
1c000034 002b0011 3 2
1c008000 0280252a 0 0
1c008004 06483800 4 0
1c000034 002b0011 3 2
1c008000 0280252a 0 0
1c008004 06483800 4 0

// ==== sources.f ====
+incdir+.
ctrl_pkg.sv
pipe_pkg.sv
if_stage.sv
id_stage.sv
ctrl.sv
frontend_top.sv
tb_frontend.sv

// ==== Makefile ====
TOP := tb_frontend

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f sources.f --top-module frontend_top

obj_dir/V$(TOP): sources.f $(wildcard *.sv *.svh) frontend_input.txt
	verilator --binary --timing --assert -f sources.f --top-module $(TOP)

sim: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) > sim.log 2>&1; cat sim.log
	@if grep -q '\*\* FAIL \*\*' sim.log; then echo "simulation reported failure"; exit 1; fi
	@grep -q '\*\* PASS \*\*' sim.log || (echo "simulation ended without a result"; exit 1)

clean:
	rm -rf obj_dir sim.log
